// ==== src.f ====
+incdir+tb
hw/gfx_pkg.sv
hw/vga_timing.sv
hw/pixel_addr.sv
hw/frame_mem.sv
hw/pixel_unpack.sv
hw/bus_port.sv
hw/graphics_controller.sv
tb/tb_graphics_controller.sv

// ==== tb/gfx_model.svh ====
`ifndef GFX_MODEL_SVH
`define GFX_MODEL_SVH

// shadow copy of frame memory and scroll register
logic [WORD_W-1:0] shadow_mem [0:FRAME_WORDS-1];
int                shadow_scroll = 0;
logic [31:0]       lcg_state = 32'hdbfc;

// lcg step, high half folded into the low bits
function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state ^ (lcg_state >> 16);
endfunction

// color of visible pixel idx for a frame shown with word offset scroll
function automatic logic [RGB_W-1:0] model_pixel(input int idx, input int scroll);
    int                word_addr;
    logic [WORD_W-1:0] word_val;
    logic [PIX_W-1:0]  nibble;
    word_addr = (idx / PIX_PER_WORD + scroll) % FRAME_WORDS;
    word_val  = shadow_mem[word_addr];
    // pixel 0 in the low nibble
    nibble    = word_val[(idx % PIX_PER_WORD) * PIX_W +: PIX_W];
    return PALETTE[nibble];
endfunction

// bus read value: memory word, pixel position or zero
function automatic logic [WORD_W-1:0] expected_rdata(input int addr, input int pos);
    logic [WORD_W-1:0] result;
    if (addr < FRAME_WORDS) begin
        result = shadow_mem[addr];
    end else if (addr == SCROLL_ADDR) begin
        result = WORD_W'(pos);
    end else begin
        result = '0;
    end
    return result;
endfunction

`endif

// ==== tb/tb_graphics_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_graphics_controller
    import gfx_pkg::*;
();

    localparam int CLK_PERIOD  = 4;
    localparam int FRAME_CLKS  = HTOL_TIME * VTOL_TIME;
    localparam int WATCHDOG_NS = 8 * FRAME_CLKS * CLK_PERIOD;
    localparam int N_ROUNDS    = 3;
    localparam int N_READS     = 256;

    logic              vga_clk;
    logic              rst;
    logic              wr_i;
    logic              rd_i;
    logic [ADDR_W-1:0] addr_i;
    logic [WORD_W-1:0] wdata_i;
    logic [WORD_W-1:0] rdata_o;
    logic              hsync_o;
    logic              vsync_o;
    logic              de_o;
    logic [RGB_W-1:0]  rgb_o;

    int               error_count = 0;
    int               vis_count = 0;
    bit               check_frame = 1'b0;
    bit               first_frame = 1'b1;
    logic [RGB_W-1:0] pix_expected;

    int   line_clks = 0;
    int   hs_clks = 0;
    int   de_clks = 0;
    int   frame_lines = 0;
    int   vs_lines = 0;
    int   de_lines = 0;
    int   frames_checked = 0;
    bit   line_seen = 1'b0;
    bit   frame_seen = 1'b0;
    logic hsync_q = 1'b1;
    logic vsync_q = 1'b1;

    `include "gfx_model.svh"

    graphics_controller graphics_controller_i (
        .vga_clk (vga_clk),
        .rst     (rst),
        .wr_i    (wr_i),
        .rd_i    (rd_i),
        .addr_i  (addr_i),
        .wdata_i (wdata_i),
        .rdata_o (rdata_o),
        .hsync_o (hsync_o),
        .vsync_o (vsync_o),
        .de_o    (de_o),
        .rgb_o   (rgb_o)
    );

    initial begin
        vga_clk = 1'b0;
        forever #(CLK_PERIOD / 2) vga_clk = ~vga_clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before the test rounds finished");
        $display("tests failed");
        $finish;
    end

    task automatic report_mismatch(input string msg);
        $display("MISMATCH at %0t: %s", $time, msg);
        error_count++;
    endtask

    task automatic write_word(input logic [ADDR_W-1:0] addr, input logic [WORD_W-1:0] data);
        wr_i    = 1'b1;
        addr_i  = addr;
        wdata_i = data;
        @(negedge vga_clk);
        wr_i = 1'b0;
    endtask

    task automatic read_and_compare(input logic [ADDR_W-1:0] addr,
                                    input logic [WORD_W-1:0] expected);
        rd_i   = 1'b1;
        addr_i = addr;
        @(negedge vga_clk);
        rd_i = 1'b0;
        if (rdata_o !== expected) begin
            report_mismatch($sformatf("read of %0d gave %h, expected %h",
                                      addr, rdata_o, expected));
        end
    endtask

    // vis_count is the index of the pixel in this cycle
    always @(negedge vga_clk) begin
        if (rst) begin
            vis_count <= 0;
        end else if (de_o) begin
            if (first_frame && vis_count < PIX_PER_WORD && rgb_o !== PALETTE[0]) begin
                report_mismatch($sformatf("pixel %0d after reset is %h", vis_count, rgb_o));
            end
            if (check_frame) begin
                pix_expected = model_pixel(vis_count, shadow_scroll);
                if (rgb_o !== pix_expected) begin
                    report_mismatch($sformatf("pixel %0d is %h, expected %h",
                                              vis_count, rgb_o, pix_expected));
                end
            end
            vis_count <= (vis_count == TOL_PXL - 1) ? 0 : vis_count + 1;
        end else if (rgb_o !== '0) begin
            report_mismatch($sformatf("rgb %h while de is low", rgb_o));
        end
    end

    // line and frame lengths measured from sync rising edges
    always @(negedge vga_clk) begin
        if (!rst) begin
            if (hsync_o && !hsync_q) begin
                if (line_seen) begin
                    if (line_clks != HTOL_TIME || hs_clks != HSYNC_TIME) begin
                        report_mismatch($sformatf("line of %0d clocks, hsync %0d",
                                                  line_clks, hs_clks));
                    end
                    if (de_clks != 0 && de_clks != HOR_PXL) begin
                        report_mismatch($sformatf("line with %0d de clocks", de_clks));
                    end
                    frame_lines++;
                    if (vsync_q) begin
                        vs_lines++;
                    end
                    if (de_clks != 0) begin
                        de_lines++;
                    end
                end
                if (vsync_o && !vsync_q) begin
                    if (frame_seen) begin
                        frames_checked++;
                        if (frame_lines != VTOL_TIME || vs_lines != VSYNC_TIME ||
                            de_lines != VER_PXL) begin
                            report_mismatch($sformatf("frame of %0d lines, vsync %0d, de %0d",
                                                      frame_lines, vs_lines, de_lines));
                        end
                    end
                    frame_seen  = 1'b1;
                    frame_lines = 0;
                    vs_lines    = 0;
                    de_lines    = 0;
                end
                line_seen = 1'b1;
                line_clks = 0;
                hs_clks   = 0;
                de_clks   = 0;
            end
            line_clks++;
            if (hsync_o) begin
                hs_clks++;
            end
            if (de_o) begin
                de_clks++;
            end
        end
        hsync_q = hsync_o;
        vsync_q = vsync_o;
    end

    initial begin
        int                target;
        logic [31:0]       raw_scroll;
        logic [ADDR_W-1:0] addr;
        rst     = 1'b1;
        wr_i    = 1'b0;
        rd_i    = 1'b0;
        addr_i  = '0;
        wdata_i = '0;
        repeat (16) @(negedge vga_clk);
        rst = 1'b0;
        if (hsync_o !== SYNC_POL || vsync_o !== SYNC_POL || de_o !== 1'b0 || rgb_o !== '0) begin
            report_mismatch("outputs not in their reset state");
        end

        @(posedge vsync_o);
        first_frame = 1'b0;
        for (int round = 0; round < N_ROUNDS; round++) begin
            // write frame
            @(negedge vga_clk);
            for (int a = 0; a < FRAME_WORDS; a++) begin
                shadow_mem[a] = next_rand();
                write_word(ADDR_W'(a), shadow_mem[a]);
            end
            if (round == 0) begin
                raw_scroll = '0;
            end else if (round == 1) begin
                raw_scroll = next_rand();
            end else begin
                raw_scroll = FRAME_WORDS + next_rand() % FRAME_WORDS;
            end
            shadow_scroll = int'(raw_scroll % FRAME_WORDS);
            write_word(ADDR_W'(SCROLL_ADDR), raw_scroll);

            // check frame with no writes
            @(posedge vsync_o);
            check_frame = 1'b1;
            @(negedge vga_clk);
            read_and_compare(ADDR_W'(SCROLL_ADDR), '0);
            for (int i = 0; i < N_READS; i++) begin
                addr = ADDR_W'(next_rand() % FRAME_WORDS);
                read_and_compare(addr, expected_rdata(addr, 0));
            end
            addr = ADDR_W'(SCROLL_ADDR + 1 + next_rand() % (2**ADDR_W - SCROLL_ADDR - 1));
            read_and_compare(addr, '0);
            target = int'(next_rand() % TOL_PXL);
            do begin
                @(negedge vga_clk);
            end while (!(de_o && vis_count == target));
            read_and_compare(ADDR_W'(SCROLL_ADDR), expected_rdata(SCROLL_ADDR, target));
            @(posedge vsync_o);
            check_frame = 1'b0;
        end

        if (frames_checked < 2 * N_ROUNDS - 1) begin
            $display("sync timing was measured over only %0d frames", frames_checked);
            error_count++;
        end

        $display("run complete, %0d errors", error_count);
        if (error_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== hw/graphics_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

module graphics_controller
    import gfx_pkg::*;
(
    input  wire logic              vga_clk,
    input  wire logic              rst,
    input  wire logic              wr_i,
    input  wire logic              rd_i,
    input  wire logic [ADDR_W-1:0] addr_i,
    input  wire logic [WORD_W-1:0] wdata_i,
    output logic      [WORD_W-1:0] rdata_o,
    output logic                   hsync_o,
    output logic                   vsync_o,
    output logic                   de_o,
    output logic      [RGB_W-1:0]  rgb_o
);

    logic [CNT_W-1:0]  pix_cnt;
    logic [ADDR_W-1:0] scroll;
    logic              mem_a_we;
    logic [ADDR_W-1:0] mem_a_addr;
    logic [WORD_W-1:0] mem_a_wdata;
    logic [WORD_W-1:0] mem_a_rdata;
    logic [ADDR_W-1:0] mem_b_addr;
    logic [WORD_W-1:0] mem_b_rdata;

    vga_timing vga_timing_i (
        .vga_clk   (vga_clk),
        .rst       (rst),
        .hsync_o   (hsync_o),
        .vsync_o   (vsync_o),
        .de_o      (de_o),
        .pix_cnt_o (pix_cnt)
    );

    // display prefetch address
    pixel_addr pixel_addr_i (
        .pix_cnt_i  (pix_cnt),
        .scroll_i   (scroll),
        .mem_addr_o (mem_b_addr)
    );

    frame_mem frame_mem_i (
        .vga_clk   (vga_clk),
        .a_we_i    (mem_a_we),
        .a_addr_i  (mem_a_addr),
        .a_wdata_i (mem_a_wdata),
        .a_rdata_o (mem_a_rdata),
        .b_addr_i  (mem_b_addr),
        .b_rdata_o (mem_b_rdata)
    );

    pixel_unpack pixel_unpack_i (
        .vga_clk    (vga_clk),
        .rst        (rst),
        .de_i       (de_o),
        .pix_cnt_i  (pix_cnt),
        .mem_data_i (mem_b_rdata),
        .rgb_o      (rgb_o)
    );

    // host side
    bus_port bus_port_i (
        .vga_clk     (vga_clk),
        .rst         (rst),
        .wr_i        (wr_i),
        .rd_i        (rd_i),
        .addr_i      (addr_i),
        .wdata_i     (wdata_i),
        .rdata_o     (rdata_o),
        .pix_cnt_i   (pix_cnt),
        .mem_we_o    (mem_a_we),
        .mem_addr_o  (mem_a_addr),
        .mem_wdata_o (mem_a_wdata),
        .mem_rdata_i (mem_a_rdata),
        .scroll_o    (scroll)
    );

endmodule

`default_nettype wire

// ==== hw/bus_port.sv ====
`timescale 1ns/1ps
`default_nettype none

module bus_port
    import gfx_pkg::*;
(
    input  wire logic              vga_clk,
    input  wire logic              rst,
    input  wire logic              wr_i,
    input  wire logic              rd_i,
    input  wire logic [ADDR_W-1:0] addr_i,
    input  wire logic [WORD_W-1:0] wdata_i,
    output logic      [WORD_W-1:0] rdata_o,
    input  wire logic [CNT_W-1:0]  pix_cnt_i,
    output logic                   mem_we_o,
    output logic      [ADDR_W-1:0] mem_addr_o,
    output logic      [WORD_W-1:0] mem_wdata_o,
    input  wire logic [WORD_W-1:0] mem_rdata_i,
    output logic      [ADDR_W-1:0] scroll_o
);

    logic              hit_mem;
    logic              hit_reg;
    logic              rd_mem_q;
    logic [WORD_W-1:0] rdata_q;

    assign hit_mem = (addr_i < ADDR_W'(FRAME_WORDS));
    assign hit_reg = (addr_i == ADDR_W'(SCROLL_ADDR));

    assign mem_we_o    = wr_i && hit_mem;
    assign mem_addr_o  = addr_i;
    assign mem_wdata_o = wdata_i;

    // scroll register, word offset kept below FRAME_WORDS
    always_ff @(posedge vga_clk or posedge rst) begin
        if (rst) begin
            scroll_o <= '0;
        end else if (wr_i && hit_reg) begin
            scroll_o <= ADDR_W'(wdata_i % FRAME_WORDS);
        end
    end

    // position and zero reads are known now, memory data one cycle later
    always_ff @(posedge vga_clk or posedge rst) begin
        if (rst) begin
            rd_mem_q <= 1'b0;
            rdata_q  <= '0;
        end else begin
            rd_mem_q <= rd_i && hit_mem;
            if (rd_i) begin
                rdata_q <= hit_reg ? WORD_W'(pix_cnt_i) : '0;
            end else if (rd_mem_q) begin
                rdata_q <= mem_rdata_i;
            end
        end
    end

    // hold the last read until the next one
    assign rdata_o = rd_mem_q ? mem_rdata_i : rdata_q;

endmodule

`default_nettype wire

// ==== hw/pixel_unpack.sv ====
`timescale 1ns/1ps
`default_nettype none

module pixel_unpack
    import gfx_pkg::*;
(
    input  wire logic              vga_clk,
    input  wire logic              rst,
    input  wire logic              de_i,
    input  wire logic [CNT_W-1:0]  pix_cnt_i,
    input  wire logic [WORD_W-1:0] mem_data_i,
    output logic      [RGB_W-1:0]  rgb_o
);

    logic [WORD_W-1:0]    pix_word;
    logic [PIX_SEL_W-1:0] pix_sel;
    logic [PIX_W-1:0]     color_idx;
    logic                 last_in_word;

    assign pix_sel      = pix_cnt_i[PIX_SEL_W-1:0];
    assign last_in_word = de_i && (pix_sel == '1);

    // take the prefetched word on the last pixel of the current one
    always_ff @(posedge vga_clk or posedge rst) begin
        if (rst) begin
            pix_word <= '0;
        end else if (last_in_word) begin
            pix_word <= mem_data_i;
        end
    end

    // pixel 0 sits in the low nibble
    assign color_idx = pix_word[pix_sel * PIX_W +: PIX_W];

    always_comb begin
        if (de_i) begin
            rgb_o = PALETTE[color_idx];
        end else begin
            rgb_o = '0;
        end
    end

endmodule

`default_nettype wire

// ==== hw/frame_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module frame_mem
    import gfx_pkg::*;
(
    input  wire logic              vga_clk,
    input  wire logic              a_we_i,
    input  wire logic [ADDR_W-1:0] a_addr_i,
    input  wire logic [WORD_W-1:0] a_wdata_i,
    output logic      [WORD_W-1:0] a_rdata_o,
    input  wire logic [ADDR_W-1:0] b_addr_i,
    output logic      [WORD_W-1:0] b_rdata_o
);

    logic [WORD_W-1:0] mem [0:FRAME_WORDS-1];

    // host port, read returns old data on a write cycle
    always_ff @(posedge vga_clk) begin
        if (a_we_i) begin
            mem[a_addr_i] <= a_wdata_i;
        end
        a_rdata_o <= mem[a_addr_i];
    end

    // display port
    always_ff @(posedge vga_clk) begin
        b_rdata_o <= mem[b_addr_i];
    end

endmodule

`default_nettype wire

// ==== hw/pixel_addr.sv ====
`timescale 1ns/1ps
`default_nettype none

module pixel_addr
    import gfx_pkg::*;
(
    input  wire logic [CNT_W-1:0]  pix_cnt_i,
    input  wire logic [ADDR_W-1:0] scroll_i,
    output logic      [ADDR_W-1:0] mem_addr_o
);

    logic [ADDR_W-1:0] cur_word;
    logic [ADDR_W:0]   sum;

    // word holding the pixel now on screen
    assign cur_word = ADDR_W'(pix_cnt_i >> PIX_SEL_W);

    // fetch one word ahead, both terms stay below FRAME_WORDS
    assign sum = {1'b0, cur_word} + {1'b0, scroll_i} + (ADDR_W + 1)'(1);

    always_comb begin
        if (sum >= (ADDR_W + 1)'(FRAME_WORDS)) begin
            mem_addr_o = ADDR_W'(sum - (ADDR_W + 1)'(FRAME_WORDS));
        end else begin
            mem_addr_o = sum[ADDR_W-1:0];
        end
    end

endmodule

`default_nettype wire

// ==== hw/vga_timing.sv ====
`timescale 1ns/1ps
`default_nettype none

module vga_timing
    import gfx_pkg::*;
(
    input  wire logic             vga_clk,
    input  wire logic             rst,
    output logic                  hsync_o,
    output logic                  vsync_o,
    output logic                  de_o,
    output logic [CNT_W-1:0]      pix_cnt_o
);

    logic [$clog2(HTOL_TIME)-1:0] x;
    logic [$clog2(VTOL_TIME)-1:0] y;
    logic                         x_wrap;
    logic                         y_wrap;
    logic                         h_vis;
    logic                         v_vis;

    assign x_wrap = (x == HTOL_TIME - 1);
    assign y_wrap = (y == VTOL_TIME - 1);

    // position counters
    always_ff @(posedge vga_clk or posedge rst) begin
        if (rst) begin
            x <= '0;
            y <= '0;
        end else begin
            if (x_wrap) begin
                x <= '0;
                if (y_wrap) begin
                    y <= '0;
                end else begin
                    y <= y + 1'b1;
                end
            end else begin
                x <= x + 1'b1;
            end
        end
    end

    // syncs change one step ahead so they line up with x and y
    always_ff @(posedge vga_clk or posedge rst) begin
        if (rst) begin
            hsync_o <= SYNC_POL;
            vsync_o <= SYNC_POL;
        end else begin
            if (x_wrap) begin
                hsync_o <= SYNC_POL;
            end else if (x == HSYNC_TIME - 1) begin
                hsync_o <= ~SYNC_POL;
            end
            if (x_wrap && y_wrap) begin
                vsync_o <= SYNC_POL;
            end else if (x_wrap && y == VSYNC_TIME - 1) begin
                vsync_o <= ~SYNC_POL;
            end
        end
    end

    assign h_vis = (x >= HPXL_BEGIN) && (x < HPXL_BEGIN + HOR_PXL);
    assign v_vis = (y >= VPXL_BEGIN) && (y < VPXL_BEGIN + VER_PXL);
    assign de_o  = h_vis && v_vis;

    // visible pixel index, holds through blanking
    always_ff @(posedge vga_clk or posedge rst) begin
        if (rst) begin
            pix_cnt_o <= '0;
        end else if (de_o) begin
            if (pix_cnt_o == CNT_W'(TOL_PXL - 1)) begin
                pix_cnt_o <= '0;
            end else begin
                pix_cnt_o <= pix_cnt_o + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/gfx_pkg.sv ====
`default_nettype none

package gfx_pkg;

    // bus and memory word
    localparam int WORD_W       = 32;
    localparam int PIX_W        = 4;
    localparam int PIX_PER_WORD = WORD_W / PIX_W;
    localparam int PIX_SEL_W    = $clog2(PIX_PER_WORD);

    // 800x600 display geometry
    localparam int HOR_PXL    = 800;
    localparam int VER_PXL    = 600;
    localparam int HSYNC_TIME = 120;
    localparam int HBACK_POCH = 64;
    localparam int HFRNT_POCH = 56;
    localparam int VSYNC_TIME = 6;
    localparam int VBACK_POCH = 23;
    localparam int VFRNT_POCH = 37;
    localparam int HTOL_TIME  = HSYNC_TIME + HBACK_POCH + HOR_PXL + HFRNT_POCH;
    localparam int VTOL_TIME  = VSYNC_TIME + VBACK_POCH + VER_PXL + VFRNT_POCH;
    localparam int HPXL_BEGIN = HSYNC_TIME + HBACK_POCH;
    localparam int VPXL_BEGIN = VSYNC_TIME + VBACK_POCH;
    localparam int TOL_PXL    = HOR_PXL * VER_PXL;

    // frame memory and bus map
    localparam int FRAME_WORDS = TOL_PXL / PIX_PER_WORD;
    localparam int ADDR_W      = 16;
    localparam int SCROLL_ADDR = FRAME_WORDS;
    localparam int CNT_W       = $clog2(TOL_PXL);

    localparam logic SYNC_POL = 1'b1;

    localparam int RGB_W = 12;

    // fixed 16 color table, 4 bits per channel
    localparam logic [RGB_W-1:0] PALETTE [0:15] = '{
        12'h000, 12'h00a, 12'h0a0, 12'h0aa,
        12'ha00, 12'ha0a, 12'ha50, 12'haaa,
        12'h555, 12'h55f, 12'h5f5, 12'h5ff,
        12'hf55, 12'hf5f, 12'hff5, 12'hfff
    };

endpackage

`default_nettype wire
